//--- dv/branch_stack_asserts.sv
/*
 * Branch stack port checks.
 * Concurrent assertions on the top-level ports, attached by bind.
 */

`timescale 1ns/10ps
`default_nettype none

module branch_stack_asserts (
	input wire logic                         clk,
	input wire logic                         rst_n_i,
	input wire logic                         is_br_i,
	input wire logic                         is_cond_i,
	input wire bs_pkg::br_rslv_t             rslv_i,
	input wire logic [bs_pkg::BR_MASK_W-1:0] br_mask_o,
	input wire logic [bs_pkg::BR_MASK_W-1:0] alloc_bit_o,
	input wire logic                         full_o
);

	// Full only when every bit is taken.
	a_full_mask: assert property (@(posedge clk) disable iff (!rst_n_i)
		full_o |-> (&br_mask_o))
		else $error("full_o high while the mask has a free bit");

	// At most one bit offered.
	a_alloc_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
		$onehot0(alloc_bit_o))
		else $error("alloc_bit_o has more than one bit set");

	// Dispatch during a mispredict is a stimulus error.
	a_no_disp_on_wrong: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(is_br_i && is_cond_i && (rslv_i.state == bs_pkg::BR_WRONG)))
		else $error("conditional dispatch attempted during a wrong resolve");

endmodule

bind branch_stack branch_stack_asserts asserts0 (
	.clk        (clk),
	.rst_n_i    (rst_n_i),
	.is_br_i    (is_br_i),
	.is_cond_i  (is_cond_i),
	.rslv_i     (rslv_i),
	.br_mask_o  (br_mask_o),
	.alloc_bit_o(alloc_bit_o),
	.full_o     (full_o)
);

`default_nettype wire

//--- dv/branch_stack_tb.sv
/*
 * Branch stack testbench.
 * Directed and random dispatch, resolve and CDB traffic, checked every
 * cycle against a reference model of the mask and checkpoint slots.
 */

`timescale 1ns/10ps
`default_nettype none

module branch_stack_tb;

	localparam int TOTAL_CYCLES = 2200;	// All tests, resets included.
	localparam int N = bs_pkg::BR_MASK_W;

	typedef struct packed {
		logic [N-1:0]  mask;
		logic [N-1:0]  abit;
		logic          full;
		logic          rc_vld;
		bs_pkg::ckpt_t rc_ckpt;
	} exp_t;

	logic                         clk;
	logic                         rst_n_i;
	logic                         is_br_i;
	logic                         is_cond_i;
	bs_pkg::ckpt_t                bak_ckpt_i;
	bs_pkg::br_rslv_t             rslv_i;
	logic                         cdb_vld_i;
	logic [bs_pkg::PRF_IDX_W-1:0] cdb_tag_i;
	logic [N-1:0]                 br_mask_o;
	logic [N-1:0]                 alloc_bit_o;
	logic                         full_o;
	logic                         rc_vld_o;
	bs_pkg::ckpt_t                rc_ckpt_o;

	// Reference model state, as of the next edge.
	logic [N-1:0]  m_mask;
	logic [N-1:0]  m_vld;
	bs_pkg::ckpt_t m_ckpt [N];
	logic [N-1:0]  m_dep [N];	// Mask each live branch saw at dispatch.

	logic [31:0] rng;
	string       cur_test;
	int          test_err;
	int          err_total;
	int          checks;
	int          tests_run;
	int          tests_bad;

	branch_stack dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [N-1:0] lowest_zero(input logic [N-1:0] m);
		for (int i = 0; i < N; i++) begin
			if (!m[i]) return N'(1) << i;
		end
		return '0;
	endfunction

	function automatic bs_pkg::br_rslv_t mk_rslv(input bs_pkg::br_state_e s,
			input logic [N-1:0] b, input logic [N-1:0] d);
		bs_pkg::br_rslv_t r;
		r.state    = s;
		r.br_bit   = b;
		r.dep_mask = d;
		return r;
	endfunction

	// Applies a CDB broadcast to one checkpoint.
	function automatic bs_pkg::ckpt_t cdb_apply(input bs_pkg::ckpt_t c,
			input logic v, input logic [bs_pkg::PRF_IDX_W-1:0] t);
		for (int e = 0; e < bs_pkg::MT_NUM; e++) begin
			if (v && c.mt[e].tag == t) c.mt[e].rdy = 1'b1;
		end
		return c;
	endfunction

	// Expected outputs in this cycle from model state and inputs.
	function automatic exp_t ref_outputs(input bs_pkg::br_rslv_t r);
		exp_t e;
		logic [N-1:0] clr;
		clr       = (r.state == bs_pkg::BR_CORRECT) ? (m_mask & ~r.br_bit) : m_mask;
		e.mask    = m_mask;
		e.abit    = lowest_zero(clr);
		e.full    = &m_mask;
		e.rc_vld  = (r.state == bs_pkg::BR_WRONG);
		e.rc_ckpt = '0;
		for (int i = 0; i < N; i++) begin
			if (e.rc_vld && r.br_bit[i]) e.rc_ckpt = m_ckpt[i];
		end
		return e;
	endfunction

	task automatic model_reset();
		m_mask = '0;
		m_vld  = '0;
		for (int i = 0; i < N; i++) begin
			m_ckpt[i] = '0;
			m_dep[i]  = '0;
		end
	endtask

	// Advances the model across one edge.
	task automatic model_step(input exp_t e);
		logic         acc;
		logic         wrong;
		logic [N-1:0] clr;
		wrong = (rslv_i.state == bs_pkg::BR_WRONG);
		acc   = is_br_i && is_cond_i && !e.full && !wrong;
		clr   = (rslv_i.state == bs_pkg::BR_CORRECT) ? (m_mask & ~rslv_i.br_bit) : m_mask;
		for (int i = 0; i < N; i++) begin
			if (acc && e.abit[i]) begin
				m_vld[i]  = 1'b1;
				m_dep[i]  = m_mask;	// Dependency is the mask in the dispatch cycle.
				m_ckpt[i] = cdb_apply(bak_ckpt_i, cdb_vld_i, cdb_tag_i);
			end else if (m_vld[i]) begin
				m_ckpt[i] = cdb_apply(m_ckpt[i], cdb_vld_i, cdb_tag_i);
				if ((rslv_i.state != bs_pkg::BR_NONE && rslv_i.br_bit[i]) ||
						(wrong && !rslv_i.dep_mask[i])) begin
					m_vld[i] = 1'b0;	// Resolved or squashed.
				end
			end
		end
		if (wrong) m_mask = rslv_i.dep_mask;
		else       m_mask = acc ? (clr | e.abit) : clr;
	endtask

	task automatic check_val(input string field, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		checks++;
		assert (exp_v === act_v) else begin
			test_err++;
			$display("FAILED %s %s expected %h actual %h", cur_test, field, exp_v, act_v);
		end
	endtask

	// Compares before each rising edge, then steps the model.
	always @(negedge clk) begin
		exp_t e;
		if (!rst_n_i) begin
			model_reset();
		end else begin
			e = ref_outputs(rslv_i);
			check_val("br_mask_o", 64'(e.mask), 64'(br_mask_o));
			check_val("alloc_bit_o", 64'(e.abit), 64'(alloc_bit_o));
			check_val("full_o", 64'(e.full), 64'(full_o));
			check_val("rc_vld_o", 64'(e.rc_vld), 64'(rc_vld_o));
			check_val("rc_ckpt_o", 64'(e.rc_ckpt), 64'(rc_ckpt_o));
			model_step(e);
		end
	end

	// Sets every DUT input, called on a rising edge.
	task automatic apply_inputs(input logic br, input logic cond, input bs_pkg::ckpt_t ck,
			input bs_pkg::br_rslv_t r, input logic cv,
			input logic [bs_pkg::PRF_IDX_W-1:0] tag);
		is_br_i    <= br;
		is_cond_i  <= cond;
		bak_ckpt_i <= ck;
		rslv_i     <= r;
		cdb_vld_i  <= cv;
		cdb_tag_i  <= tag;
	endtask

	task automatic drive(input logic br, input logic cond, input bs_pkg::ckpt_t ck,
			input bs_pkg::br_rslv_t r, input logic cv,
			input logic [bs_pkg::PRF_IDX_W-1:0] tag);
		@(posedge clk);
		apply_inputs(br, cond, ck, r, cv, tag);
	endtask

	task automatic idle();
		drive(1'b0, 1'b0, '0, mk_rslv(bs_pkg::BR_NONE, '0, '0), 1'b0, '0);
	endtask

	task automatic do_reset();
		@(posedge clk);
		rst_n_i <= 1'b0;
		idle();
		repeat (7) @(posedge clk);
		rst_n_i <= 1'b1;
	endtask

	function automatic bs_pkg::ckpt_t rand_ckpt();
		logic [63:0] w;
		rng = xorshift(rng);
		w[63:32] = rng;
		rng = xorshift(rng);
		w[31:0] = rng;
		return bs_pkg::ckpt_t'(w[56:0]);
	endfunction

	task automatic start_test(input string name);
		cur_test = name;
		test_err = 0;
		do_reset();
	endtask

	task automatic finish_test();
		idle();
		@(posedge clk);	// The negedge check of the last cycle is counted by now.
		tests_run++;
		err_total += test_err;
		if (test_err == 0) begin
			$display("%s: ok", cur_test);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", cur_test, test_err);
		end
	endtask

	// Wrong resolve with an independent check of the recovered state.
	task automatic wrong_and_check(input logic [N-1:0] b, input logic [N-1:0] d,
			input bs_pkg::ckpt_t exp_ck);
		drive(1'b0, 1'b0, '0, mk_rslv(bs_pkg::BR_WRONG, b, d), 1'b0, '0);
		@(negedge clk);
		check_val("recovered rc_vld_o", 64'd1, 64'(rc_vld_o));
		check_val("recovered rc_ckpt_o", 64'(exp_ck), 64'(rc_ckpt_o));
	endtask

	task automatic random_mix(input int cycles);
		bs_pkg::br_rslv_t r;
		bs_pkg::ckpt_t    ck;
		logic             br;
		logic             cond;
		int               idx;
		for (int c = 0; c < cycles; c++) begin
			@(posedge clk);	// Model holds the state of the cycle being driven.
			ck = rand_ckpt();
			r = mk_rslv(bs_pkg::BR_NONE, '0, '0);
			rng = xorshift(rng);
			if (m_mask != '0 && rng[1:0] == 2'd0) begin
				idx = int'(rng[9:8]);
				while (!m_mask[idx]) idx = (idx + 1) % N;	// Live bits only.
				r.br_bit   = N'(1) << idx;
				r.dep_mask = m_dep[idx] & m_mask & ~r.br_bit;
				r.state    = (rng[5:4] == 2'd0) ? bs_pkg::BR_WRONG : bs_pkg::BR_CORRECT;
			end
			br   = rng[12] && (r.state != bs_pkg::BR_WRONG);
			cond = rng[14:13] != 2'd0;
			apply_inputs(br, cond, ck, r, rng[16], rng[24:20]);
		end
	endtask

	initial begin
		bs_pkg::ckpt_t ck [N];
		bs_pkg::ckpt_t tmp;
		rst_n_i    = 1'b0;
		is_br_i    = 1'b0;
		is_cond_i  = 1'b0;
		bak_ckpt_i = '0;
		rslv_i     = '0;
		cdb_vld_i  = 1'b0;
		cdb_tag_i  = '0;
		rng        = 32'hcb2b_5127;
		err_total  = 0;
		checks     = 0;
		tests_run  = 0;
		tests_bad  = 0;

		start_test("alloc_full");
		drive(1'b1, 1'b0, rand_ckpt(), mk_rslv(bs_pkg::BR_NONE, '0, '0), 1'b0, '0);
		for (int i = 0; i < N; i++) begin
			drive(1'b1, 1'b1, rand_ckpt(), mk_rslv(bs_pkg::BR_NONE, '0, '0), 1'b0, '0);
		end
		idle();
		drive(1'b1, 1'b1, rand_ckpt(), mk_rslv(bs_pkg::BR_CORRECT, 4'b0100, 4'b0011),
			1'b0, '0);	// Still full, so the freed bit is not taken.
		finish_test();

		start_test("correct_resolve");
		for (int i = 0; i < N; i++) begin
			drive(1'b1, 1'b1, rand_ckpt(), mk_rslv(bs_pkg::BR_NONE, '0, '0), 1'b0, '0);
		end
		drive(1'b0, 1'b0, '0, mk_rslv(bs_pkg::BR_CORRECT, 4'b0100, 4'b0011), 1'b0, '0);
		drive(1'b1, 1'b1, rand_ckpt(), mk_rslv(bs_pkg::BR_NONE, '0, '0), 1'b0, '0);
		drive(1'b0, 1'b0, '0, mk_rslv(bs_pkg::BR_CORRECT, 4'b1000, 4'b0111), 1'b0, '0);
		drive(1'b1, 1'b1, rand_ckpt(), mk_rslv(bs_pkg::BR_CORRECT, 4'b0010, 4'b0001),
			1'b0, '0);	// Freed bit goes straight to this dispatch.
		finish_test();

		start_test("wrong_resolve");
		for (int i = 0; i < N; i++) begin
			ck[i] = rand_ckpt();
			drive(1'b1, 1'b1, ck[i], mk_rslv(bs_pkg::BR_NONE, '0, '0), 1'b0, '0);
		end
		idle();
		wrong_and_check(4'b0010, 4'b0001, ck[1]);
		idle();
		ck[1] = rand_ckpt();
		drive(1'b1, 1'b1, ck[1], mk_rslv(bs_pkg::BR_NONE, '0, '0), 1'b0, '0);
		idle();
		wrong_and_check(4'b0010, 4'b0001, ck[1]);
		finish_test();

		start_test("cdb_update");
		tmp = rand_ckpt();
		for (int e = 0; e < bs_pkg::MT_NUM; e++) begin
			tmp.mt[e].tag = 5'(e + 8);
			tmp.mt[e].rdy = (e == 5);	// Broadcast before the save.
		end
		drive(1'b1, 1'b1, tmp, mk_rslv(bs_pkg::BR_NONE, '0, '0), 1'b1, 5'd8);
		idle();
		drive(1'b0, 1'b0, '0, mk_rslv(bs_pkg::BR_NONE, '0, '0), 1'b1, 5'd11);
		drive(1'b0, 1'b0, '0, mk_rslv(bs_pkg::BR_NONE, '0, '0), 1'b1, 5'd30);
		tmp.mt[0].rdy = 1'b1;
		tmp.mt[3].rdy = 1'b1;
		wrong_and_check(4'b0001, 4'b0000, tmp);
		finish_test();

		start_test("random_mix");
		random_mix(2000);
		finish_test();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_bad, checks, err_total);
		if (err_total == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Ends a hung run.
	initial begin
		#(TOTAL_CYCLES * 10 + 2000);
		$display("watchdog timeout, the tests did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
verilog/bs_pkg.sv
verilog/br_mask_ctrl.sv
verilog/br_stack_ent.sv
verilog/br_rc_select.sv
verilog/branch_stack.sv
dv/branch_stack_asserts.sv
dv/branch_stack_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the branch stack testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module branch_stack_tb -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
	exit 1
fi
exit 0

//--- verilog/br_mask_ctrl.sv
/*
 * Branch mask controller.
 * Keeps the mask of branches in flight, picks the lowest free bit
 * for a dispatched conditional branch and flags the stack full.
 */

`timescale 1ns/10ps
`default_nettype none

module br_mask_ctrl (
	input  wire logic                         clk,
	input  wire logic                         rst_n_i,
	input  wire logic                         is_br_i,		// Dispatch strobe.
	input  wire logic                         is_cond_i,	// Only conditional branches count.
	input  wire bs_pkg::br_rslv_t             rslv_i,		// Resolve from the ROB.
	output logic      [bs_pkg::BR_MASK_W-1:0] br_mask_o,	// Current mask.
	output logic      [bs_pkg::BR_MASK_W-1:0] alloc_bit_o,	// Bit offered to dispatch.
	output logic                              alloc_o,		// Dispatch accepted.
	output logic                              full_o		// All bits taken.
);

	logic [bs_pkg::BR_MASK_W-1:0] mask_q;
	logic [bs_pkg::BR_MASK_W-1:0] mask_clr;	// Mask after a correct clear.
	logic [bs_pkg::BR_MASK_W-1:0] mask_d;
	logic                         rslv_ok;
	logic                         rslv_bad;

	assign rslv_ok  = (rslv_i.state == bs_pkg::BR_CORRECT);
	assign rslv_bad = (rslv_i.state == bs_pkg::BR_WRONG);

	// A correct resolve frees its bit in the same cycle.
	assign mask_clr = rslv_ok ? (mask_q & ~rslv_i.br_bit) : mask_q;

	// Lowest zero bit, low to high.
	always_comb begin
		logic found;
		found       = 1'b0;
		alloc_bit_o = '0;
		for (int i = 0; i < bs_pkg::BR_MASK_W; i++) begin
			if (!mask_clr[i] && !found) begin
				alloc_bit_o[i] = 1'b1;
				found          = 1'b1;
			end
		end
	end

	assign full_o = &mask_q;	// Registered, so it trails the edge by a cycle.

	// Unconditional branches never take a bit.
	// No dispatch is taken while a mispredict is being recovered.
	assign alloc_o = is_br_i & is_cond_i & ~full_o & ~rslv_bad;

	// Wrong override first, then correct clear, then allocation.
	always_comb begin
		if (rslv_bad) begin
			mask_d = rslv_i.dep_mask;	// Roll back to the branch's view.
		end else if (alloc_o) begin
			mask_d = mask_clr | alloc_bit_o;
		end else begin
			mask_d = mask_clr;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			mask_q <= '0;	// Nothing in flight.
		end else begin
			mask_q <= mask_d;
		end
	end

	assign br_mask_o = mask_q;

endmodule

`default_nettype wire

//--- verilog/br_rc_select.sv
/*
 * Recovery selector.
 * On a mispredict, drives out the checkpoint of the resolving
 * branch's slot with zero latency; drives zeros otherwise.
 */

`timescale 1ns/10ps
`default_nettype none

module br_rc_select (
	input  wire bs_pkg::br_rslv_t                        rslv_i,
	input  wire bs_pkg::ckpt_t [bs_pkg::BR_MASK_W-1:0]   slot_ckpt_i,	// Every slot's copy.
	output logic                                         rc_vld_o,		// Recover now.
	output bs_pkg::ckpt_t                                rc_ckpt_o		// State to restore.
);

	always_comb begin
		rc_vld_o  = 1'b0;
		rc_ckpt_o = '0;	// Quiet when not recovering.
		if (rslv_i.state == bs_pkg::BR_WRONG) begin
			rc_vld_o = 1'b1;
			// br_bit is one-hot, so one slot matches.
			for (int i = 0; i < bs_pkg::BR_MASK_W; i++) begin
				if (rslv_i.br_bit[i]) begin
					rc_ckpt_o = slot_ckpt_i[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/br_stack_ent.sv
/*
 * Branch checkpoint slot.
 * Captures the map table and queue pointers on allocation, keeps the
 * saved ready bits current from the CDB and drops out when squashed.
 */

`timescale 1ns/10ps
`default_nettype none

module br_stack_ent (
	input  wire logic                         clk,
	input  wire logic                         rst_n_i,
	input  wire logic                         sel_i,		// This slot's bit of the alloc bit.
	input  wire logic                         alloc_i,		// Dispatch accepted.
	input  wire bs_pkg::br_rslv_t             rslv_i,		// Resolve, seen from this slot.
	input  wire bs_pkg::ckpt_t                bak_ckpt_i,	// State to save.
	input  wire logic                         cdb_vld_i,
	input  wire logic [bs_pkg::PRF_IDX_W-1:0] cdb_tag_i,
	output bs_pkg::ckpt_t                     ckpt_o		// Saved state.
);

	// The resolve view keeps only this slot's bit in br_bit and
	// forces every other dep_mask bit to one.

	logic          vld_q;
	logic          cap;			// Capture this cycle.
	logic          own_done;	// Own branch resolved.
	logic          squash;
	bs_pkg::ckpt_t ckpt_q;
	bs_pkg::ckpt_t ckpt_d;

	assign cap      = alloc_i & sel_i;
	assign own_done = (rslv_i.state != bs_pkg::BR_NONE) & (|rslv_i.br_bit);

	// An older mispredict whose dep_mask lacks this bit kills it too.
	assign squash = own_done |
		((rslv_i.state == bs_pkg::BR_WRONG) & ~(&rslv_i.dep_mask));

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			vld_q <= 1'b0;
		end else if (cap) begin
			vld_q <= 1'b1;	// Wins over a same-cycle correct clear of the bit.
		end else if (squash) begin
			vld_q <= 1'b0;
		end
	end

	// Fresh data when capturing, else the held copy.
	// A CDB hit marks the matching entries ready either way.
	always_comb begin
		ckpt_d = cap ? bak_ckpt_i : ckpt_q;
		if (cdb_vld_i) begin
			for (int e = 0; e < bs_pkg::MT_NUM; e++) begin
				if (ckpt_d.mt[e].tag == cdb_tag_i) begin
					ckpt_d.mt[e].rdy = 1'b1;
				end
			end
		end
	end

	// Payload only moves while the slot is live or loading.
	always_ff @(posedge clk) begin
		if (cap || vld_q) begin
			ckpt_q <= ckpt_d;
		end
	end

	assign ckpt_o = ckpt_q;	// State as of the last edge.

endmodule

`default_nettype wire

//--- verilog/branch_stack.sv
/*
 * Branch checkpoint stack.
 * Mask controller hands out branch bits, one slot per bit holds the
 * saved checkpoint and the selector presents it on a mispredict.
 */

`timescale 1ns/10ps
`default_nettype none

module branch_stack (
	input  wire logic                         clk,
	input  wire logic                         rst_n_i,
	input  wire logic                         is_br_i,		// Dispatch strobe.
	input  wire logic                         is_cond_i,
	input  wire bs_pkg::ckpt_t                bak_ckpt_i,	// Map table, FL head, SQ tail.
	input  wire bs_pkg::br_rslv_t             rslv_i,		// From the ROB.
	input  wire logic                         cdb_vld_i,
	input  wire logic [bs_pkg::PRF_IDX_W-1:0] cdb_tag_i,
	output logic      [bs_pkg::BR_MASK_W-1:0] br_mask_o,	// Dependency mask for dispatch.
	output logic      [bs_pkg::BR_MASK_W-1:0] alloc_bit_o,	// New branch's tag.
	output logic                              full_o,		// Stall dispatch.
	output logic                              rc_vld_o,
	output bs_pkg::ckpt_t                     rc_ckpt_o
);

	logic                                      alloc;
	bs_pkg::br_rslv_t [bs_pkg::BR_MASK_W-1:0] slot_rslv;	// Per-slot resolve view.
	bs_pkg::ckpt_t    [bs_pkg::BR_MASK_W-1:0] slot_ckpt;

	br_mask_ctrl mask_ctrl0 (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.is_br_i    (is_br_i),
		.is_cond_i  (is_cond_i),
		.rslv_i     (rslv_i),
		.br_mask_o  (br_mask_o),
		.alloc_bit_o(alloc_bit_o),
		.alloc_o    (alloc),
		.full_o     (full_o)
	);

	// One slot per mask bit.
	for (genvar i = 0; i < bs_pkg::BR_MASK_W; i++) begin : g_ent
		logic [bs_pkg::BR_MASK_W-1:0] own;	// This slot's bit.

		// Slot sees only its own bit of the resolve.
		always_comb begin
			own                    = '0;
			own[i]                 = 1'b1;
			slot_rslv[i]           = rslv_i;
			slot_rslv[i].br_bit    = rslv_i.br_bit & own;
			slot_rslv[i].dep_mask  = rslv_i.dep_mask | ~own;
		end

		br_stack_ent ent (
			.clk       (clk),
			.rst_n_i   (rst_n_i),
			.sel_i     (alloc_bit_o[i]),
			.alloc_i   (alloc),
			.rslv_i    (slot_rslv[i]),
			.bak_ckpt_i(bak_ckpt_i),
			.cdb_vld_i (cdb_vld_i),
			.cdb_tag_i (cdb_tag_i),
			.ckpt_o    (slot_ckpt[i])
		);
	end

	br_rc_select rc_sel0 (
		.rslv_i     (rslv_i),
		.slot_ckpt_i(slot_ckpt),
		.rc_vld_o   (rc_vld_o),
		.rc_ckpt_o  (rc_ckpt_o)
	);

endmodule

`default_nettype wire

//--- verilog/bs_pkg.sv
/*
 * Branch stack package.
 * Sizes, resolve state encoding and the packed types for the saved
 * checkpoint and the resolved-branch record.
 */

`default_nettype none

package bs_pkg;

	// Sizes.
	localparam int BR_MASK_W = 4;	// Branches in flight, one mask bit each.
	localparam int MT_NUM    = 8;	// Architectural registers in the map table.
	localparam int PRF_IDX_W = 5;	// Physical register tag width.
	localparam int FL_PTR_W  = 4;	// Free-list pointer, wrap bit sits above it.
	localparam int SQ_IDX_W  = 3;	// Store-queue index, wrap bit sits above it.

	// Resolve state coming from the ROB.
	typedef enum logic [1:0] {
		BR_NONE    = 2'd0,	// Nothing resolved this cycle.
		BR_CORRECT = 2'd1,	// Prediction held.
		BR_WRONG   = 2'd2	// Mispredict, recover.
	} br_state_e;

	// One map table entry.
	typedef struct packed {
		logic [PRF_IDX_W-1:0] tag;	// Physical register.
		logic                 rdy;	// Value already on the CDB.
	} map_ent_t;

	// Saved machine state for one branch, 57 bits.
	typedef struct packed {
		map_ent_t [MT_NUM-1:0] mt;		// Whole map table.
		logic [FL_PTR_W:0]     fl_head;	// Free-list head with wrap bit.
		logic [SQ_IDX_W:0]     sq_tail;	// Store-queue tail with wrap bit.
	} ckpt_t;

	// Resolved branch record, 10 bits.
	// The one-hot field is br_bit since bit is a reserved word.
	typedef struct packed {
		br_state_e            state;	// NONE, CORRECT or WRONG.
		logic [BR_MASK_W-1:0] br_bit;	// Branch's own one-hot mask bit.
		logic [BR_MASK_W-1:0] dep_mask;	// Mask seen at dispatch, own bit excluded.
	} br_rslv_t;

endpackage

`default_nettype wire
